// File: common/battle_pkg.sv
package battle_pkg;

    // Board coordinates and cell contents
    typedef logic [3:0] coord_t;
    typedef logic [1:0] cell_t;

    localparam cell_t CELL_EMPTY = 2'd0;
    localparam cell_t CELL_SHIP  = 2'd1;
    localparam cell_t CELL_HIT   = 2'd2;
    localparam cell_t CELL_MISS  = 2'd3;

    // Fleet, placed in this order
    typedef logic [2:0] ship_t;
    typedef logic [2:0] len_t;

    localparam ship_t CARRIER    = 3'd0;
    localparam ship_t BATTLESHIP = 3'd1;
    localparam ship_t CRUISER    = 3'd2;
    localparam ship_t SUBMARINE  = 3'd3;
    localparam ship_t DESTROYER  = 3'd4;

    localparam int NUM_SHIPS = 5;

    // Indexed by ship_t
    localparam len_t SHIP_LEN [NUM_SHIPS] = '{3'd5, 3'd4, 3'd3, 3'd3, 3'd2};

    // Game phases
    typedef enum logic [1:0] {
        PH_INIT   = 2'd0,
        PH_SETUP  = 2'd1,
        PH_GAME   = 2'd2,
        PH_FINISH = 2'd3
    } phase_e;

    // Key commands written to REG_CMD
    typedef logic [2:0] cmd_t;

    localparam cmd_t CMD_UP     = 3'd0;
    localparam cmd_t CMD_DOWN   = 3'd1;
    localparam cmd_t CMD_LEFT   = 3'd2;
    localparam cmd_t CMD_RIGHT  = 3'd3;
    localparam cmd_t CMD_ROTATE = 3'd4;
    localparam cmd_t CMD_ENTER  = 3'd5;
    localparam cmd_t CMD_FIRE   = 3'd6;
    localparam cmd_t CMD_POWER  = 3'd7;  // Submarine chain power

    // APB bus
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t REG_CMD      = 8'h00;  // WO
    localparam apb_addr_t REG_STATUS   = 8'h04;  // RO
    localparam apb_addr_t REG_POS      = 8'h08;  // RO
    localparam apb_addr_t REG_CELL_SEL = 8'h0C;  // RW
    localparam apb_addr_t REG_CELL     = 8'h10;  // RO

endpackage

// File: common/board_if.sv
interface board_if;
    import battle_pkg::*;

    // Control side
    logic   place_en;
    logic   fire_en;
    logic   clear_en;
    logic   player;    // Board addressed, 0 is player 1's
    coord_t x;
    coord_t y;
    logic   vertical;
    len_t   len;

    // Board status
    logic   place_ok;
    cell_t  target_cell;
    logic   alive_p1;
    logic   alive_p2;

    // Host read port
    logic   rd_board;
    coord_t rd_x;
    coord_t rd_y;
    cell_t  rd_cell;

    modport ctrl (output place_en, fire_en, clear_en, player, x, y, vertical, len,
                  input  place_ok, target_cell, alive_p1, alive_p2);
    modport store (input  place_en, fire_en, clear_en, player, x, y, vertical, len,
                   output place_ok, target_cell, alive_p1, alive_p2);
    modport host (output rd_board, rd_x, rd_y, input rd_cell);
    modport store_rd (input rd_board, rd_x, rd_y, output rd_cell);

endinterface

// File: game/board_store.sv
module board_store #(
    parameter int BOARD_SIZE = 10
) (
    input  logic      clk,
    input  logic      rst,
    board_if.store    brd,
    board_if.store_rd host
);
    import battle_pkg::*;

    cell_t      board [2][BOARD_SIZE][BOARD_SIZE];  // [player][row][col]
    logic [4:0] span_end;
    logic       place_ok;
    logic [1:0] alive;

    // One past the last cell the ship covers along its axis
    assign span_end = (brd.vertical ? {1'b0, brd.y} : {1'b0, brd.x}) + 5'(brd.len);

    function automatic logic in_span(int r, int c);
        if (brd.vertical) begin
            return (c == brd.x) && (r >= brd.y) && (r < span_end);
        end else begin
            return (r == brd.y) && (c >= brd.x) && (c < span_end);
        end
    endfunction

    // Edge check, then overlap with ships already placed
    always_comb begin
        place_ok = (span_end <= 5'(BOARD_SIZE));
        for (int r = 0; r < BOARD_SIZE; r++) begin
            for (int c = 0; c < BOARD_SIZE; c++) begin
                if (in_span(r, c) && board[brd.player][r][c] != CELL_EMPTY) place_ok = 1'b0;
            end
        end
    end

    always_comb begin
        alive = 2'b00;
        for (int p = 0; p < 2; p++) begin
            for (int r = 0; r < BOARD_SIZE; r++) begin
                for (int c = 0; c < BOARD_SIZE; c++) begin
                    if (board[p][r][c] == CELL_SHIP) alive[p] = 1'b1;
                end
            end
        end
    end

    assign brd.place_ok    = place_ok;
    assign brd.alive_p1    = alive[0];
    assign brd.alive_p2    = alive[1];
    assign brd.target_cell = board[brd.player][brd.y][brd.x];

    // Selection outside the board reads as empty
    assign host.rd_cell = (host.rd_x < BOARD_SIZE && host.rd_y < BOARD_SIZE) ?
                          board[host.rd_board][host.rd_y][host.rd_x] : CELL_EMPTY;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int p = 0; p < 2; p++) begin
                for (int r = 0; r < BOARD_SIZE; r++) begin
                    for (int c = 0; c < BOARD_SIZE; c++) begin
                        board[p][r][c] <= CELL_EMPTY;
                    end
                end
            end
        end else if (brd.clear_en) begin
            // New game after finish
            for (int p = 0; p < 2; p++) begin
                for (int r = 0; r < BOARD_SIZE; r++) begin
                    for (int c = 0; c < BOARD_SIZE; c++) begin
                        board[p][r][c] <= CELL_EMPTY;
                    end
                end
            end
        end else if (brd.place_en) begin
            for (int r = 0; r < BOARD_SIZE; r++) begin
                for (int c = 0; c < BOARD_SIZE; c++) begin
                    if (in_span(r, c)) board[brd.player][r][c] <= CELL_SHIP;
                end
            end
        end else if (brd.fire_en) begin
            // Hit and miss cells stay as they are
            if (brd.target_cell == CELL_SHIP) begin
                board[brd.player][brd.y][brd.x] <= CELL_HIT;
            end else if (brd.target_cell == CELL_EMPTY) begin
                board[brd.player][brd.y][brd.x] <= CELL_MISS;
            end
        end
    end

endmodule

// File: game/game_ctrl.sv
module game_ctrl #(
    parameter int BOARD_SIZE  = 10,
    parameter int WARN_CYCLES = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    input  battle_pkg::cmd_t      cmd,
    output battle_pkg::apb_data_t status,
    output battle_pkg::coord_t    pos_x,
    output battle_pkg::coord_t    pos_y,
    board_if.ctrl                 brd
);
    import battle_pkg::*;

    localparam coord_t MAX_POS = coord_t'(BOARD_SIZE - 1);
    localparam int     WARN_W  = $clog2(WARN_CYCLES + 1);

    phase_e            phase;
    ship_t             cur_ship;
    logic              vertical;
    logic              player1_turn;
    logic              chain;
    logic              power_p1;
    logic              power_p2;
    logic              warn;
    logic [WARN_W-1:0] warn_cnt;
    logic              in_battle;
    logic              moving;
    logic              power_ok;
    logic              reject;

    // Battle only while both fleets float
    assign in_battle = (phase == PH_GAME) && brd.alive_p1 && brd.alive_p2;
    assign moving    = (phase == PH_SETUP) || (phase == PH_GAME);
    assign power_ok  = (phase == PH_GAME) && (player1_turn ? power_p1 : power_p2);
    assign reject    = cmd_valid && ((cmd == CMD_POWER && !power_ok) ||
                       (cmd == CMD_ENTER && phase == PH_SETUP && !brd.place_ok));

    assign brd.place_en = cmd_valid && cmd == CMD_ENTER && phase == PH_SETUP && brd.place_ok;
    assign brd.fire_en  = cmd_valid && cmd == CMD_FIRE && in_battle;
    assign brd.clear_en = cmd_valid && cmd == CMD_ENTER && phase == PH_FINISH;
    // Own board in setup, opponent's in battle
    assign brd.player   = (phase == PH_SETUP) ? ~player1_turn : player1_turn;
    assign brd.x        = pos_x;
    assign brd.y        = pos_y;
    assign brd.vertical = vertical;
    assign brd.len      = SHIP_LEN[cur_ship];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase        <= PH_INIT;
            cur_ship     <= CARRIER;
            vertical     <= 1'b0;
            player1_turn <= 1'b1;
            chain        <= 1'b0;
            power_p1     <= 1'b1;
            power_p2     <= 1'b1;
            pos_x        <= '0;
            pos_y        <= '0;
            warn         <= 1'b0;
            warn_cnt     <= '0;
        end else begin
            if (reject) begin
                warn     <= 1'b1;
                warn_cnt <= WARN_W'(WARN_CYCLES - 1);
            end else if (warn) begin
                if (warn_cnt == '0) warn <= 1'b0;
                else warn_cnt <= warn_cnt - 1'b1;
            end

            if (phase == PH_GAME && !in_battle) begin
                phase <= PH_FINISH;
            end else if (cmd_valid) begin
                case (cmd)
                    CMD_UP:    if (moving && pos_y != 0) pos_y <= pos_y - 1'b1;
                    CMD_DOWN:  if (moving && pos_y != MAX_POS) pos_y <= pos_y + 1'b1;
                    CMD_LEFT:  if (moving && pos_x != 0) pos_x <= pos_x - 1'b1;
                    CMD_RIGHT: if (moving && pos_x != MAX_POS) pos_x <= pos_x + 1'b1;
                    CMD_ROTATE: if (phase == PH_SETUP) vertical <= ~vertical;
                    CMD_ENTER: begin
                        if (phase == PH_INIT) begin
                            phase <= PH_SETUP;
                        end else if (phase == PH_SETUP && brd.place_ok) begin
                            if (cur_ship != DESTROYER) begin
                                cur_ship <= cur_ship + 1'b1;
                            end else begin
                                cur_ship     <= CARRIER;
                                player1_turn <= ~player1_turn;  // P2 sets up, or P1 opens fire
                                if (!player1_turn) begin
                                    phase <= PH_GAME;
                                    pos_x <= '0;
                                    pos_y <= '0;
                                end
                            end
                        end else if (phase == PH_FINISH) begin
                            phase        <= PH_INIT;
                            cur_ship     <= CARRIER;
                            vertical     <= 1'b0;
                            player1_turn <= 1'b1;
                            chain        <= 1'b0;
                            power_p1     <= 1'b1;
                            power_p2     <= 1'b1;
                            pos_x        <= '0;
                            pos_y        <= '0;
                        end
                    end
                    CMD_FIRE: begin
                        // Only a hit inside an active chain keeps the turn
                        if (in_battle && !(brd.target_cell == CELL_SHIP && chain)) begin
                            chain        <= 1'b0;
                            player1_turn <= ~player1_turn;
                        end
                    end
                    CMD_POWER: begin
                        if (power_ok) begin
                            chain <= 1'b1;
                            if (player1_turn) power_p1 <= 1'b0;
                            else power_p2 <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        status       = '0;
        status[1:0]  = phase;
        status[2]    = player1_turn;
        status[3]    = warn;
        status[4]    = chain;
        status[5]    = power_p1;
        status[6]    = power_p2;
        status[10:8] = cur_ship;
        status[12]   = (phase == PH_FINISH) && !brd.alive_p2;
    end

endmodule

// File: hdl/apb_regs.sv
module apb_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  battle_pkg::apb_addr_t paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  battle_pkg::apb_data_t pwdata,
    output battle_pkg::apb_data_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  cmd_valid,
    output battle_pkg::cmd_t      cmd,
    input  battle_pkg::apb_data_t status,
    input  battle_pkg::coord_t    pos_x,
    input  battle_pkg::coord_t    pos_y,
    board_if.host                 host
);
    import battle_pkg::*;

    logic   access;
    logic   hit_cmd;
    logic   hit_ro;
    logic   hit_sel;
    coord_t sel_x;
    coord_t sel_y;
    logic   sel_board;

    assign access  = psel && penable;
    assign pready  = access;  // No wait states

    assign hit_cmd = (paddr == REG_CMD);
    assign hit_sel = (paddr == REG_CELL_SEL);
    assign hit_ro  = (paddr == REG_STATUS) || (paddr == REG_POS) || (paddr == REG_CELL);

    // Unmapped, write to RO, or read of WO
    assign pslverr = access && (!(hit_cmd || hit_sel || hit_ro) ||
                                (pwrite && hit_ro) || (!pwrite && hit_cmd));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= access && pwrite && hit_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (access && pwrite && hit_cmd) begin
            cmd <= pwdata[2:0];
        end
    end

    // Cell select register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_x     <= '0;
            sel_y     <= '0;
            sel_board <= 1'b0;
        end else if (access && pwrite && hit_sel) begin
            sel_x     <= pwdata[3:0];
            sel_y     <= pwdata[7:4];
            sel_board <= pwdata[8];
        end
    end

    assign host.rd_board = sel_board;
    assign host.rd_x     = sel_x;
    assign host.rd_y     = sel_y;

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_STATUS:   prdata = status;
            REG_POS:      prdata[7:0] = {pos_y, pos_x};
            REG_CELL_SEL: prdata[8:0] = {sel_board, sel_y, sel_x};
            REG_CELL:     prdata[1:0] = host.rd_cell;
            default: ;
        endcase
    end

endmodule

// File: hdl/battleship_top.sv
module battleship_top #(
    parameter int BOARD_SIZE  = 10,
    parameter int WARN_CYCLES = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  battle_pkg::apb_addr_t paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  battle_pkg::apb_data_t pwdata,
    output battle_pkg::apb_data_t prdata,
    output logic                  pready,
    output logic                  pslverr
);
    import battle_pkg::*;

    logic      cmd_valid;
    cmd_t      cmd;
    apb_data_t status;
    coord_t    pos_x;
    coord_t    pos_y;

    board_if u_brd ();

    apb_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .status    (status),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .host      (u_brd)
    );

    game_ctrl #(
        .BOARD_SIZE  (BOARD_SIZE),
        .WARN_CYCLES (WARN_CYCLES)
    ) u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .status    (status),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .brd       (u_brd)
    );

    board_store #(
        .BOARD_SIZE (BOARD_SIZE)
    ) u_store (
        .clk  (clk),
        .rst  (rst),
        .brd  (u_brd),
        .host (u_brd)
    );

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_battleship -f src.f

out=$(./obj_dir/Vtb_battleship) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Testbench passed"

// File: src.f
common/battle_pkg.sv
common/board_if.sv
hdl/apb_regs.sv
game/game_ctrl.sv
game/board_store.sv
hdl/battleship_top.sv
tests/battleship_properties.sv
tests/tb_battleship.sv

// File: tests/battleship_properties.sv
module battleship_properties (
    input logic       clk,
    input logic       rst,
    input logic       psel,
    input logic       penable,
    input logic       pready,
    input logic       cmd_valid,
    input logic [1:0] phase
);
    timeunit 1ns;
    timeprecision 100ps;
    import battle_pkg::*;

    int fail_count = 0;

    // Zero wait states
    apb_no_wait: assert property (@(posedge clk) disable iff (rst)
        pready == (psel && penable))
        else begin
            $error("pready differs from psel and penable");
            fail_count++;
        end

    cmd_one_cycle: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |=> !cmd_valid)
        else begin
            $error("cmd_valid held longer than one cycle");
            fail_count++;
        end

    finish_to_init: assert property (@(posedge clk) disable iff (rst)
        (phase == PH_FINISH) |=> (phase == PH_FINISH || phase == PH_INIT))
        else begin
            $error("phase left finish for a state other than init");
            fail_count++;
        end

endmodule

// File: tests/tb_battleship.sv
module tb_battleship;
    timeunit 1ns;
    timeprecision 100ps;
    import battle_pkg::*;

    localparam int BOARD_SIZE  = 10;
    localparam int WARN_CYCLES = 16;
    localparam int APB_TIMEOUT = 8;
    localparam int FLEET_LEN [NUM_SHIPS] = '{5, 4, 3, 3, 2};  // Ship i lies in row i

    logic      clk;
    logic      rst;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    integer    seed = 91048;

    battleship_top #(
        .BOARD_SIZE  (BOARD_SIZE),
        .WARN_CYCLES (WARN_CYCLES)
    ) u_dut (.*);

    bind battleship_top battleship_properties u_props (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pready    (pready),
        .cmd_valid (cmd_valid),
        .phase     (status[1:0])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_now($sformatf("** Error: %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Setup phase, then access phase, sampled mid-cycle
    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        int waited;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready) begin
            waited++;
            if (waited > APB_TIMEOUT) fail_now("APB transfer got no pready in time");
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t ignored;
        apb_access(1'b1, addr, data, ignored, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
        logic err;
        apb_read(addr, data, err);
        check_value("pslverr", err, 1'b0);
    endtask

    task automatic send_cmd(input cmd_t c);
        logic err;
        apb_write(REG_CMD, {29'd0, c}, err);
        check_value("pslverr", err, 1'b0);
        repeat (3) @(posedge clk);  // Command and any phase change settle
    endtask

    task automatic check_status(input phase_e ph, input logic p1_turn, input logic chain_exp,
                                output apb_data_t s);
        read_reg(REG_STATUS, s);
        check_value("status.phase", s[1:0], ph);
        check_value("status.player1_turn", s[2], p1_turn);
        check_value("status.chain", s[4], chain_exp);
    endtask

    task automatic check_cell(input logic b, input int x, input int y, input cell_t exp);
        apb_data_t d;
        logic err;
        apb_write(REG_CELL_SEL, {23'd0, b, 4'(y), 4'(x)}, err);
        check_value("pslverr", err, 1'b0);
        read_reg(REG_CELL, d);
        check_value($sformatf("cell[%0d][%0d][%0d]", b, y, x), d, 32'(exp));
    endtask

    task automatic move_to(input int x, input int y);
        apb_data_t p;
        read_reg(REG_POS, p);
        for (int i = int'(p[3:0]); i < x; i++) send_cmd(CMD_RIGHT);
        for (int i = int'(p[3:0]); i > x; i--) send_cmd(CMD_LEFT);
        for (int i = int'(p[7:4]); i < y; i++) send_cmd(CMD_DOWN);
        for (int i = int'(p[7:4]); i > y; i--) send_cmd(CMD_UP);
        read_reg(REG_POS, p);
        check_value("pos", p, 32'(y * 16 + x));
    endtask

    task automatic fire_at(input int x, input int y);
        move_to(x, y);
        send_cmd(CMD_FIRE);
    endtask

    // Rows 5 and up hold no ships on either board
    task automatic fire_miss(input logic shooter_p1);
        int x;
        int y;
        x = int'($unsigned($random(seed)) % BOARD_SIZE);
        y = 5 + int'($unsigned($random(seed)) % (BOARD_SIZE - 5));
        fire_at(x, y);
        check_cell(shooter_p1, x, y, CELL_MISS);
    endtask

    task automatic place_ship(input logic b, input int ship);
        apb_data_t s;
        read_reg(REG_STATUS, s);
        check_value("status.ship", s[10:8], ship);
        move_to(0, ship);
        send_cmd(CMD_ENTER);
        for (int x = 0; x <= FLEET_LEN[ship]; x++) begin
            check_cell(b, x, ship, (x < FLEET_LEN[ship]) ? CELL_SHIP : CELL_EMPTY);
        end
    endtask

    task automatic wait_warn_clear();
        apb_data_t s;
        int waited;
        waited = 0;
        read_reg(REG_STATUS, s);
        while (s[3]) begin
            waited += 3;  // Cycles per APB read
            if (waited > WARN_CYCLES + 12) fail_now("warn stayed up past its time limit");
            read_reg(REG_STATUS, s);
        end
    endtask

    task automatic after_reset();
        apb_data_t d;
        logic err;
        check_status(PH_INIT, 1'b1, 1'b0, d);
        check_value("status.warn", d[3], 1'b0);
        check_value("status.powers", d[6:5], 2'b11);
        read_reg(REG_POS, d);
        check_value("pos", d, 0);
        apb_read(REG_CMD, d, err);
        check_value("pslverr", err, 1'b1);
        send_cmd(CMD_ENTER);
        check_status(PH_SETUP, 1'b1, 1'b0, d);
    endtask

    task automatic setup_moves_and_limits();
        apb_data_t d;
        send_cmd(CMD_LEFT);
        send_cmd(CMD_UP);
        read_reg(REG_POS, d);
        check_value("pos", d, 0);
        repeat (BOARD_SIZE + 2) send_cmd(CMD_RIGHT);
        read_reg(REG_POS, d);
        check_value("pos.x", d[3:0], BOARD_SIZE - 1);
        send_cmd(CMD_ENTER);  // Carrier runs past the right edge
        check_status(PH_SETUP, 1'b1, 1'b0, d);
        check_value("status.warn", d[3], 1'b1);
        check_value("status.ship", d[10:8], CARRIER);
        wait_warn_clear();
        for (int x = BOARD_SIZE - 5; x < BOARD_SIZE; x++) check_cell(1'b0, x, 0, CELL_EMPTY);
        place_ship(1'b0, 0);
        move_to(2, 0);
        send_cmd(CMD_ENTER);  // Battleship across the carrier
        check_status(PH_SETUP, 1'b1, 1'b0, d);
        check_value("status.warn", d[3], 1'b1);
        check_value("status.ship", d[10:8], BATTLESHIP);
        check_cell(1'b0, 5, 0, CELL_EMPTY);
    endtask

    task automatic fleet_placement();
        apb_data_t d;
        for (int i = 1; i < NUM_SHIPS; i++) place_ship(1'b0, i);
        check_status(PH_SETUP, 1'b0, 1'b0, d);
        for (int i = 0; i < NUM_SHIPS; i++) place_ship(1'b1, i);
        check_status(PH_GAME, 1'b1, 1'b0, d);
        read_reg(REG_POS, d);
        check_value("pos", d, 0);
    endtask

    task automatic battle_turns();
        apb_data_t d;
        fire_miss(1'b1);
        check_status(PH_GAME, 1'b0, 1'b0, d);
        fire_at(0, 0);  // Player 2 hits, no chain
        check_cell(1'b0, 0, 0, CELL_HIT);
        check_status(PH_GAME, 1'b1, 1'b0, d);
        send_cmd(CMD_POWER);
        check_status(PH_GAME, 1'b1, 1'b1, d);
        check_value("status.powers", d[6:5], 2'b10);
        fire_at(0, 0);
        check_cell(1'b1, 0, 0, CELL_HIT);
        check_status(PH_GAME, 1'b1, 1'b1, d);
        fire_at(1, 0);
        check_cell(1'b1, 1, 0, CELL_HIT);
        check_status(PH_GAME, 1'b1, 1'b1, d);
        fire_miss(1'b1);  // Chain ends here
        check_status(PH_GAME, 1'b0, 1'b0, d);
        fire_miss(1'b0);
        wait_warn_clear();
        send_cmd(CMD_POWER);  // Power already spent
        check_status(PH_GAME, 1'b1, 1'b0, d);
        check_value("status.warn", d[3], 1'b1);
        check_value("status.powers", d[6:5], 2'b10);
        fire_at(0, 0);  // Wasted shot
        check_cell(1'b1, 0, 0, CELL_HIT);
        check_status(PH_GAME, 1'b0, 1'b0, d);
    endtask

    task automatic win_and_restart();
        apb_data_t d;
        for (int y = 0; y < NUM_SHIPS; y++) begin
            for (int x = 0; x < FLEET_LEN[y]; x++) begin
                if (!(y == 0 && x < 2)) begin
                    fire_miss(1'b0);
                    fire_at(x, y);
                    check_cell(1'b1, x, y, CELL_HIT);
                end
            end
        end
        check_status(PH_FINISH, 1'b0, 1'b0, d);
        check_value("status.p1_wins", d[12], 1'b1);
        send_cmd(CMD_ENTER);
        check_status(PH_INIT, 1'b1, 1'b0, d);
        check_value("status.powers", d[6:5], 2'b11);
        check_value("status.ship", d[10:8], CARRIER);
        for (int b = 0; b < 2; b++) begin
            for (int y = 0; y < BOARD_SIZE; y++) begin
                for (int x = 0; x < BOARD_SIZE; x++) check_cell(b[0], x, y, CELL_EMPTY);
            end
        end
    endtask

    initial begin
        rst     <= 1'b1;
        paddr   <= '0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        pwdata  <= '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        after_reset();
        setup_moves_and_limits();
        fleet_placement();
        battle_turns();
        win_and_restart();
        if (u_dut.u_props.fail_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "Bound properties failed");
        end
    end

endmodule
